//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= lsu_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
verilog/mem_op_pkg.sv
verilog/mem_word_pkg.sv
verilog/ex_mem_req.sv
verilog/data_sram.sv
verilog/mem_stage.sv
verilog/lsu_top.sv
tb/tb_clk_gen.sv
tb/lsu_tb.sv

//--- tb/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;
	import mem_op_pkg::*;

	logic        clk;
	logic        arst_n;
	logic        req_valid;
	memop_t      req_op;
	logic [31:0] req_base;
	logic [15:0] req_offset;
	logic [31:0] req_store_data;
	logic [31:0] req_alu;
	logic [4:0]  req_waddr;
	logic [31:0] req_pc;
	logic        stall;
	logic        flush;
	wire         req_ready;
	wire [4:0]   wb_waddr;
	wire [31:0]  wb_wdata;
	wire [3:0]   wb_wren;
	wire [31:0]  wb_pc;
	wire [4:0]   fwd_waddr;
	wire [31:0]  fwd_wdata;
	wire         fwd_nofwd;

	logic [31:0] shadow [64];
	logic [31:0] rng;
	int          errors;
	int          accepted;
	int          retired;
	int          dropped;

	// every driven cycle gets its own pc so results can be counted at wb
	logic [29:0] pc_seq;
	logic [31:0] last_pc;

	// model of the EX/MEM and MEM/WB contents
	// a bubble is all zero
	logic        ex_v;
	logic        ex_load;
	logic [4:0]  ex_waddr;
	logic [31:0] ex_alu;
	logic [31:0] ex_wdata;
	logic [3:0]  ex_wren;
	logic [31:0] ex_pc;
	logic [4:0]  wb_e_waddr;
	logic [31:0] wb_e_wdata;
	logic [3:0]  wb_e_wren;
	logic [31:0] wb_e_pc;

	tb_clk_gen u_clk (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	lsu_top #(
		.ADDR_W (10)
	) dut0 (
		.clk              (clk),
		.arst_n_i         (arst_n),
		.stall_i          (stall),
		.flush_i          (flush),
		.req_valid_i      (req_valid),
		.req_op_i         (req_op),
		.req_base_i       (req_base),
		.req_offset_i     (req_offset),
		.req_store_data_i (req_store_data),
		.req_alu_i        (req_alu),
		.req_waddr_i      (req_waddr),
		.req_pc_i         (req_pc),
		.req_ready_o      (req_ready),
		.wb_waddr_o       (wb_waddr),
		.wb_wdata_o       (wb_wdata),
		.wb_wren_o        (wb_wren),
		.wb_pc_o          (wb_pc),
		.fwd_waddr_o      (fwd_waddr),
		.fwd_wdata_o      (fwd_wdata),
		.fwd_nofwd_o      (fwd_nofwd)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// {wren, wdata} for one operation against the word it reads
	function automatic logic [35:0] expected_wb(input memop_t op, input logic [1:0] low,
			input logic [31:0] alu, input logic [4:0] waddr, input logic [31:0] word);
		logic [7:0]  b;
		logic [15:0] h;
		logic [1:0]  lwl_sh;
		logic [31:0] d;
		logic [3:0]  en;
		b      = 8'(word >> {low, 3'b000});
		h      = 16'(word >> {low[1], 4'b0000});
		lwl_sh = 2'd3 - low;
		d      = alu;
		en     = (waddr != 5'd0) ? 4'b1111 : 4'b0000;
		if (op[MOP_LB]) d = {{24{b[7]}}, b};
		else if (op[MOP_LBU]) d = {24'h0, b};
		else if (op[MOP_LH]) d = {{16{h[15]}}, h};
		else if (op[MOP_LHU]) d = {16'h0, h};
		else if (op[MOP_LW]) d = word;
		else if (op[MOP_LWL]) begin
			d  = word << {lwl_sh, 3'b000};
			en = 4'b1111 << lwl_sh;
		end else if (op[MOP_LWR]) begin
			d  = word >> {low, 3'b000};
			en = 4'b1111 >> low;
		end else if (op & MOP_STORE_MASK) en = 4'b0000;
		if (waddr == 5'd0) en = 4'b0000;
		return {en, d};
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	// reference pipeline advancing on the same edges as the DUT
	always @(posedge clk) begin
		logic [35:0] r;
		logic [31:0] a;
		logic [5:0]  w;
		if (arst_n) begin
			check("req_ready_o", 32'(req_ready), 32'(!stall));
		end
		if (arst_n && !stall) begin
			if (flush) begin
				if (ex_v) dropped++;
				{ex_v, ex_load, ex_waddr, ex_alu, ex_wdata, ex_wren, ex_pc} = '0;
				{wb_e_waddr, wb_e_wdata, wb_e_wren, wb_e_pc} = '0;
			end else begin
				{wb_e_waddr, wb_e_wdata, wb_e_wren, wb_e_pc} =
					{ex_waddr, ex_wdata, ex_wren, ex_pc};
				if (req_valid) begin
					a = req_base + {{16{req_offset[15]}}, req_offset};
					w = a[7:2];
					r = expected_wb(req_op, a[1:0], req_alu, req_waddr, shadow[w]);
					accepted++;
					ex_v     = 1'b1;
					ex_load  = |(req_op & MOP_LOAD_MASK);
					ex_waddr = req_waddr;
					ex_alu   = req_alu;
					{ex_wren, ex_wdata} = r;
					ex_pc    = req_pc;
					if (req_op[MOP_SB]) begin
						shadow[w][{a[1:0], 3'b000} +: 8] = req_store_data[7:0];
					end else if (req_op[MOP_SH]) begin
						shadow[w][{a[1], 4'b0000} +: 16] = req_store_data[15:0];
					end else if (req_op[MOP_SW]) begin
						shadow[w] = req_store_data;
					end
				end else begin
					{ex_v, ex_load, ex_waddr, ex_alu, ex_wdata, ex_wren, ex_pc} = '0;
				end
			end
		end
	end

	// registered outputs have settled by the falling edge
	// a new nonzero pc at wb is one retired request
	always @(negedge clk) begin
		if (arst_n) begin
			check("wb_waddr_o", 32'(wb_waddr), 32'(wb_e_waddr));
			check("wb_wdata_o", wb_wdata, wb_e_wdata);
			check("wb_wren_o", 32'(wb_wren), 32'(wb_e_wren));
			check("wb_pc_o", wb_pc, wb_e_pc);
			check("fwd_waddr_o", 32'(fwd_waddr), 32'(ex_waddr));
			check("fwd_wdata_o", fwd_wdata, ex_alu);
			check("fwd_nofwd_o", 32'(fwd_nofwd), 32'(ex_load));
			if (wb_pc != 32'h0 && wb_pc != last_pc) begin
				retired++;
			end
			last_pc = wb_pc;
		end
	end

	// one cycle of stimulus
	// the byte address is built from a word and an offset
	task automatic drive(input logic v, input memop_t op, input logic [5:0] word,
			input logic [1:0] low, input logic [31:0] data, input logic [4:0] waddr,
			input logic st, input logic fl);
		logic [31:0] a;
		@(negedge clk);
		rng            = xorshift(rng);
		a              = {24'h0, word, low};
		req_valid      = v;
		req_op         = op;
		req_offset     = rng[15:0];
		req_base       = a - {{16{rng[15]}}, rng[15:0]};
		req_store_data = data;
		req_alu        = rng ^ 32'h5a5a_0f0f;
		req_waddr      = waddr;
		req_pc         = {pc_seq, 2'b00};
		pc_seq         = pc_seq + 30'd1;
		stall          = st;
		flush          = fl;
	endtask

	task automatic op_cycle(input int bit_pos, input logic [5:0] word, input logic [1:0] low,
			input logic [31:0] data, input logic [4:0] waddr);
		drive(1'b1, memop_t'(1) << bit_pos, word, low, data, waddr, 1'b0, 1'b0);
	endtask

	initial begin
		int          t;
		int          k;
		logic [1:0]  low;
		memop_t      op;
		errors = 0;
		accepted = 0;
		retired = 0;
		dropped = 0;
		rng = 32'h08ce_7e13;
		pc_seq = 30'd1;
		last_pc = '0;
		{ex_v, ex_load, ex_waddr, ex_alu, ex_wdata, ex_wren, ex_pc} = '0;
		{wb_e_waddr, wb_e_wdata, wb_e_wren, wb_e_pc} = '0;
		req_valid = 0;
		req_op = '0;
		req_base = '0;
		req_offset = '0;
		req_store_data = '0;
		req_alu = '0;
		req_waddr = '0;
		req_pc = '0;
		stall = 0;
		flush = 0;
		t = 0;
		while (!arst_n && t < 50) begin
			@(posedge clk);
			t++;
		end
		if (!arst_n) begin
			$display("reset never released");
			errors++;
		end
		@(negedge clk);
		check("wb_wren_o after reset", 32'(wb_wren), 32'h0);
		check("fwd_waddr_o after reset", 32'(fwd_waddr), 32'h0);

		// fill the tested words so every later read is defined
		for (int w = 0; w < 64; w++) begin
			rng = xorshift(rng);
			op_cycle(MOP_SW, w[5:0], 2'd0, rng, 5'd0);
		end
		// byte and halfword stores followed by every load at every legal offset
		for (int i = 0; i < 4; i++) begin
			op_cycle(MOP_SB, 6'd1, i[1:0], 32'h80 + i * 32'h31, 5'd0);
		end
		op_cycle(MOP_SH, 6'd2, 2'd2, 32'h0000_9abc, 5'd0);
		for (int i = 0; i < 4; i++) begin
			op_cycle(MOP_LB, 6'd1, i[1:0], 0, 5'd3);
			op_cycle(MOP_LBU, 6'd1, i[1:0], 0, 5'd4);
			op_cycle(MOP_LH, 6'd2, {i[1], 1'b0}, 0, 5'd5);
			op_cycle(MOP_LHU, 6'd2, {i[1], 1'b0}, 0, 5'd6);
			op_cycle(MOP_LW, i[5:0], 2'd0, 0, 5'd7);
			op_cycle(MOP_LWL, 6'd9, i[1:0], 0, 5'd8);
			op_cycle(MOP_LWR, 6'd9, i[1:0], 0, 5'd9);
		end

		// flush drops the load in flight and the store offered with it
		op_cycle(MOP_LW, 6'd3, 2'd0, 0, 5'd10);
		drive(1'b1, memop_t'(1) << MOP_SW, 6'd5, 2'd0, 32'hdead_beef, 5'd0, 1'b0, 1'b1);
		op_cycle(MOP_LW, 6'd5, 2'd0, 0, 5'd11);

		// random traffic with stalls and the odd flush
		for (int n = 0; n < 400; n++) begin
			rng = xorshift(rng);
			k   = int'(rng[3:0]) % 11;
			op  = (k == 0) ? memop_t'(0) : memop_t'(1) << (k - 1);
			low = rng[5:4];
			if (op & MOP_HALF_MASK) low[0] = 1'b0;
			if (op[MOP_LW] || op[MOP_SW]) low = 2'b00;
			drive(rng[6] | rng[7], op, rng[13:8], low, xorshift(rng), rng[20:16],
				rng[22:21] == 2'b00, rng[27:23] == 5'd0);
		end

		// drain until every accepted request has retired or been flushed
		t = 0;
		drive(1'b0, '0, 6'd0, 2'd0, 0, 5'd0, 1'b0, 1'b0);
		while (accepted != retired + dropped && t < 20) begin
			@(negedge clk);
			t++;
		end
		@(negedge clk);
		if (accepted != retired + dropped) begin
			$display("accepted %0d requests but saw %0d results and %0d flushed",
				accepted, retired, dropped);
			errors++;
		end
		$display("errors %0d, accepted %0d, retired %0d, flushed %0d",
			errors, accepted, retired, dropped);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic arst_n_o
);
	// 4 ns period, reset held low for the first 3 cycles
	initial begin
		clk_o    = 1'b0;
		arst_n_o = 1'b0;
		repeat (3) begin
			#2 clk_o = 1'b1;
			#2 clk_o = 1'b0;
		end
		arst_n_o = 1'b1;
		forever begin
			#2 clk_o = ~clk_o;
		end
	end

endmodule

`default_nettype wire

//--- verilog/data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module data_sram #(
	parameter int ADDR_W = 10
) (
	input  wire                      clk,
	input  wire                      arst_n_i,
	input  wire                      stall_i,

	input  wire                      mem_en_i,
	input  wire mem_word_pkg::byte_en_t mem_we_i,
	input  wire [ADDR_W-1:0]         mem_addr_i,
	input  wire [31:0]               mem_wdata_i,
	output logic [31:0]              mem_rdata_o
);
	import mem_word_pkg::*;

	localparam int DEPTH = 2 ** ADDR_W;

	mem_word_u mem [DEPTH];
	mem_word_u wr_word;
	logic      access;

	assign wr_word = mem_word_u'(mem_wdata_i);

	// a stalled pipeline neither reads nor writes
	assign access = mem_en_i & ~stall_i;

	// byte-lane write
	always_ff @(posedge clk) begin
		if (access) begin
			for (int i = 0; i < 4; i++) begin
				if (mem_we_i[i]) begin
					mem[mem_addr_i].lanes[i] <= wr_word.lanes[i];
				end
			end
		end
	end

	// read data register
	// keeps its value while stalled so the memory stage
	// still sees the load data once the stall drops
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mem_rdata_o <= '0;
		end else if (access) begin
			mem_rdata_o <= mem[mem_addr_i].word;
		end
	end

	// store lanes come only with a live request from the EX side
	a_we_needs_en: assert property (@(posedge clk) disable iff (!arst_n_i)
		mem_we_i != '0 |-> mem_en_i);

endmodule

`default_nettype wire

//--- verilog/ex_mem_req.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_req #(
	parameter int ADDR_W = 10
) (
	input  wire                       clk,
	input  wire                       arst_n_i,
	input  wire                       stall_i,
	input  wire                       flush_i,

	input  wire                       req_valid_i,
	input  wire mem_op_pkg::memop_t   req_op_i,
	input  wire [31:0]                req_base_i,
	input  wire [15:0]                req_offset_i,
	input  wire [31:0]                req_store_data_i,
	input  wire [31:0]                req_alu_i,
	input  wire [4:0]                 req_waddr_i,
	input  wire [31:0]                req_pc_i,
	output logic                      req_ready_o,

	output logic                      mem_en_o,
	output mem_word_pkg::byte_en_t    mem_we_o,
	output logic [ADDR_W-1:0]         mem_addr_o,
	output logic [31:0]               mem_wdata_o,

	output mem_op_pkg::memop_t        exm_op_o,
	output logic [1:0]                exm_addr_low_o,
	output logic [31:0]               exm_alu_o,
	output logic [4:0]                exm_waddr_o,
	output logic [31:0]               exm_pc_o,

	// bypass toward the decode stage
	output logic [4:0]                fwd_waddr_o,
	output logic [31:0]               fwd_wdata_o,
	output logic                      fwd_nofwd_o
);
	import mem_op_pkg::*;
	import mem_word_pkg::*;

	logic        take;
	logic        accept;
	logic [31:0] addr;
	byte_en_t    lanes;

	// the pipeline only advances when not stalled
	assign req_ready_o = ~stall_i;
	assign take        = req_valid_i & req_ready_o;
	assign accept      = take & ~flush_i;

	assign addr       = req_base_i + {{16{req_offset_i[15]}}, req_offset_i};
	assign mem_en_o   = accept;
	assign mem_addr_o = addr[ADDR_W+1:2];
	assign mem_we_o   = accept ? lanes : '0;

	// store lanes and lane-replicated store data
	always_comb begin
		lanes       = '0;
		mem_wdata_o = req_store_data_i;
		if (req_op_i[MOP_SB]) begin
			lanes       = byte_en_t'(4'b0001 << addr[1:0]);
			mem_wdata_o = {4{req_store_data_i[7:0]}};
		end else if (req_op_i[MOP_SH]) begin
			lanes       = addr[1] ? 4'b1100 : 4'b0011;
			mem_wdata_o = {2{req_store_data_i[15:0]}};
		end else if (req_op_i[MOP_SW]) begin
			lanes       = 4'b1111;
		end
	end

	// EX/MEM register, a bubble when nothing is accepted
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			exm_op_o       <= '0;
			exm_addr_low_o <= '0;
			exm_alu_o      <= '0;
			exm_waddr_o    <= '0;
			exm_pc_o       <= '0;
		end else if (!stall_i) begin
			if (accept) begin
				exm_op_o       <= req_op_i;
				exm_addr_low_o <= addr[1:0];
				exm_alu_o      <= req_alu_i;
				exm_waddr_o    <= req_waddr_i;
				exm_pc_o       <= req_pc_i;
			end else begin
				exm_op_o       <= '0;
				exm_addr_low_o <= '0;
				exm_alu_o      <= '0;
				exm_waddr_o    <= '0;
				exm_pc_o       <= '0;
			end
		end
	end

	// load data only exists after the sram read, so no bypass yet
	assign fwd_waddr_o = exm_waddr_o;
	assign fwd_wdata_o = exm_alu_o;
	assign fwd_nofwd_o = |(exm_op_o & MOP_LOAD_MASK);

	// only lwl/lwr may address a word at an unaligned offset
	a_half_align: assert property (@(posedge clk) disable iff (!arst_n_i)
		take && |(req_op_i & MOP_HALF_MASK) |-> !addr[0]);
	a_word_align: assert property (@(posedge clk) disable iff (!arst_n_i)
		take && (req_op_i[MOP_LW] || req_op_i[MOP_SW]) |-> addr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- verilog/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
	parameter int ADDR_W = 10
) (
	input  wire                      clk,
	input  wire                      arst_n_i,
	input  wire                      stall_i,
	input  wire                      flush_i,

	input  wire                      req_valid_i,
	input  wire mem_op_pkg::memop_t  req_op_i,
	input  wire [31:0]               req_base_i,
	input  wire [15:0]               req_offset_i,
	input  wire [31:0]               req_store_data_i,
	input  wire [31:0]               req_alu_i,
	input  wire [4:0]                req_waddr_i,
	input  wire [31:0]               req_pc_i,
	output wire                      req_ready_o,

	output wire [4:0]                wb_waddr_o,
	output wire [31:0]               wb_wdata_o,
	output wire [3:0]                wb_wren_o,
	output wire [31:0]               wb_pc_o,

	output wire [4:0]                fwd_waddr_o,
	output wire [31:0]               fwd_wdata_o,
	output wire                      fwd_nofwd_o
);
	import mem_op_pkg::*;
	import mem_word_pkg::*;

	// producer to sram
	wire                mem_en;
	wire byte_en_t      mem_we;
	wire [ADDR_W-1:0]   mem_addr;
	wire [31:0]         mem_wdata;

	// sram to memory stage
	wire [31:0]         mem_rdata;

	// EX/MEM register contents
	wire memop_t        exm_op;
	wire [1:0]          exm_addr_low;
	wire [31:0]         exm_alu;
	wire [4:0]          exm_waddr;
	wire [31:0]         exm_pc;

	ex_mem_req #(
		.ADDR_W (ADDR_W)
	) u_req (
		.clk              (clk),
		.arst_n_i         (arst_n_i),
		.stall_i          (stall_i),
		.flush_i          (flush_i),
		.req_valid_i      (req_valid_i),
		.req_op_i         (req_op_i),
		.req_base_i       (req_base_i),
		.req_offset_i     (req_offset_i),
		.req_store_data_i (req_store_data_i),
		.req_alu_i        (req_alu_i),
		.req_waddr_i      (req_waddr_i),
		.req_pc_i         (req_pc_i),
		.req_ready_o      (req_ready_o),
		.mem_en_o         (mem_en),
		.mem_we_o         (mem_we),
		.mem_addr_o       (mem_addr),
		.mem_wdata_o      (mem_wdata),
		.exm_op_o         (exm_op),
		.exm_addr_low_o   (exm_addr_low),
		.exm_alu_o        (exm_alu),
		.exm_waddr_o      (exm_waddr),
		.exm_pc_o         (exm_pc),
		.fwd_waddr_o      (fwd_waddr_o),
		.fwd_wdata_o      (fwd_wdata_o),
		.fwd_nofwd_o      (fwd_nofwd_o)
	);

	data_sram #(
		.ADDR_W (ADDR_W)
	) u_sram (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.stall_i     (stall_i),
		.mem_en_i    (mem_en),
		.mem_we_i    (mem_we),
		.mem_addr_i  (mem_addr),
		.mem_wdata_i (mem_wdata),
		.mem_rdata_o (mem_rdata)
	);

	mem_stage u_mem (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.stall_i        (stall_i),
		.flush_i        (flush_i),
		.mem_rdata_i    (mem_rdata),
		.exm_op_i       (exm_op),
		.exm_addr_low_i (exm_addr_low),
		.exm_alu_i      (exm_alu),
		.exm_waddr_i    (exm_waddr),
		.exm_pc_i       (exm_pc),
		.wb_waddr_o     (wb_waddr_o),
		.wb_wdata_o     (wb_wdata_o),
		.wb_wren_o      (wb_wren_o),
		.wb_pc_o        (wb_pc_o)
	);

endmodule

`default_nettype wire

//--- verilog/mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

	// one-hot memory operation code
	// all bits clear marks a non-memory instruction
	typedef logic [9:0] memop_t;

	// bit positions inside memop_t
	localparam int MOP_LB  = 0;
	localparam int MOP_LBU = 1;
	localparam int MOP_LH  = 2;
	localparam int MOP_LHU = 3;
	localparam int MOP_LW  = 4;
	localparam int MOP_SB  = 5;
	localparam int MOP_SH  = 6;
	localparam int MOP_SW  = 7;
	localparam int MOP_LWL = 8;
	localparam int MOP_LWR = 9;

	// every op that returns data from memory to the register file
	localparam memop_t MOP_LOAD_MASK =
		(memop_t'(1) << MOP_LB)  |
		(memop_t'(1) << MOP_LBU) |
		(memop_t'(1) << MOP_LH)  |
		(memop_t'(1) << MOP_LHU) |
		(memop_t'(1) << MOP_LW)  |
		(memop_t'(1) << MOP_LWL) |
		(memop_t'(1) << MOP_LWR);

	// every op that writes the data sram
	localparam memop_t MOP_STORE_MASK =
		(memop_t'(1) << MOP_SB) |
		(memop_t'(1) << MOP_SH) |
		(memop_t'(1) << MOP_SW);

	// halfword accesses, address bit 0 must be clear
	localparam memop_t MOP_HALF_MASK =
		(memop_t'(1) << MOP_LH)  |
		(memop_t'(1) << MOP_LHU) |
		(memop_t'(1) << MOP_SH);

endpackage

`default_nettype wire

//--- verilog/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input  wire                      clk,
	input  wire                      arst_n_i,
	input  wire                      stall_i,
	input  wire                      flush_i,

	// data sram read word, one cycle after the request
	input  wire [31:0]               mem_rdata_i,

	input  wire mem_op_pkg::memop_t  exm_op_i,
	input  wire [1:0]                exm_addr_low_i,
	input  wire [31:0]               exm_alu_i,
	input  wire [4:0]                exm_waddr_i,
	input  wire [31:0]               exm_pc_i,

	output logic [4:0]               wb_waddr_o,
	output logic [31:0]              wb_wdata_o,
	output logic [3:0]               wb_wren_o,
	output logic [31:0]              wb_pc_o
);
	import mem_op_pkg::*;
	import mem_word_pkg::*;

	mem_word_u   rd;
	logic [7:0]  sel_byte;
	logic [15:0] sel_half;
	logic [31:0] lwl_res;
	logic [31:0] lwr_res;
	logic [3:0]  lwl_wren;
	logic [3:0]  lwr_wren;
	logic [31:0] load_res;
	logic        is_load;
	logic        is_store;
	logic [31:0] wdata_next;
	logic [3:0]  wren_next;

	assign rd = mem_word_u'(mem_rdata_i);

	// byte and halfword picked out of the read word
	assign sel_byte = rd.lanes[exm_addr_low_i];
	assign sel_half = exm_addr_low_i[1] ?
		{rd.lanes[HALF_HI_LANE+1], rd.lanes[HALF_HI_LANE]} :
		{rd.lanes[HALF_LO_LANE+1], rd.lanes[HALF_LO_LANE]};

	// lwl fills from the top, lwr from the bottom
	// the register file merges the remaining bytes via wren
	always_comb begin
		case (exm_addr_low_i)
			2'd0: begin
				lwl_res  = {rd.word[7:0], 24'b0};
				lwl_wren = 4'b1000;
				lwr_res  = rd.word;
				lwr_wren = 4'b1111;
			end
			2'd1: begin
				lwl_res  = {rd.word[15:0], 16'b0};
				lwl_wren = 4'b1100;
				lwr_res  = {8'b0, rd.word[31:8]};
				lwr_wren = 4'b0111;
			end
			2'd2: begin
				lwl_res  = {rd.word[23:0], 8'b0};
				lwl_wren = 4'b1110;
				lwr_res  = {16'b0, rd.word[31:16]};
				lwr_wren = 4'b0011;
			end
			default: begin
				lwl_res  = rd.word;
				lwl_wren = 4'b1111;
				lwr_res  = {24'b0, rd.word[31:24]};
				lwr_wren = 4'b0001;
			end
		endcase
	end

	// load result by operation
	always_comb begin
		load_res = rd.word;
		if (exm_op_i[MOP_LB]) begin
			load_res = {{24{sel_byte[7]}}, sel_byte};
		end else if (exm_op_i[MOP_LBU]) begin
			load_res = {24'b0, sel_byte};
		end else if (exm_op_i[MOP_LH]) begin
			load_res = {{16{sel_half[15]}}, sel_half};
		end else if (exm_op_i[MOP_LHU]) begin
			load_res = {16'b0, sel_half};
		end else if (exm_op_i[MOP_LWL]) begin
			load_res = lwl_res;
		end else if (exm_op_i[MOP_LWR]) begin
			load_res = lwr_res;
		end
	end

	assign is_load    = |(exm_op_i & MOP_LOAD_MASK);
	assign is_store   = |(exm_op_i & MOP_STORE_MASK);
	assign wdata_next = is_load ? load_res : exm_alu_i;

	// r0 is never written, stores write no register
	always_comb begin
		if (is_store || exm_waddr_i == 5'd0) begin
			wren_next = 4'b0000;
		end else if (exm_op_i[MOP_LWL]) begin
			wren_next = lwl_wren;
		end else if (exm_op_i[MOP_LWR]) begin
			wren_next = lwr_wren;
		end else begin
			wren_next = 4'b1111;
		end
	end

	// MEM/WB register
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_waddr_o <= '0;
			wb_wdata_o <= '0;
			wb_wren_o  <= '0;
			wb_pc_o    <= '0;
		end else if (!stall_i) begin
			if (flush_i) begin
				wb_waddr_o <= '0;
				wb_wdata_o <= '0;
				wb_wren_o  <= '0;
				wb_pc_o    <= '0;
			end else begin
				wb_waddr_o <= exm_waddr_i;
				wb_wdata_o <= wdata_next;
				wb_wren_o  <= wren_next;
				wb_pc_o    <= exm_pc_i;
			end
		end
	end

	// EX/MEM holds at most one decoded operation
	a_op_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
		$onehot0(exm_op_i));

endmodule

`default_nettype wire

//--- verilog/mem_word_pkg.sv
`default_nettype none

package mem_word_pkg;

	// one enable per byte lane, lane 0 is bits 7:0
	typedef logic [3:0] byte_en_t;

	// a data word seen either whole or as four byte lanes
	// lanes[0] aliases word[7:0], lanes[3] aliases word[31:24]
	typedef union packed {
		logic [31:0]      word;
		logic [3:0][7:0]  lanes;
	} mem_word_u;

	// halfword select helpers for the lane view
	localparam int HALF_LO_LANE = 0;
	localparam int HALF_HI_LANE = 2;

endpackage

`default_nettype wire
